/* all.f */
rs_pkg.sv
rs_alloc.sv
rs_entry_array.sv
rs_issue_select.sv
rs_alu_top.sv
rs_alu_chk.sv
tb_rs_alu.sv

/* rs_alloc.sv */
`default_nettype none

module rs_alloc import rs_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         start,
    input  rs_dispatch_t dispatch,
    input  wakeup_t      wakeup [rs_num_buses],
    output logic         wr_en,
    output rs_ptr_t      wr_ptr,
    output rs_entry_t    wr_entry,
    output rs_ptr_t      tail
);

    logic src1_bypass;
    logic src2_bypass;

    // tail wraps naturally at rs_depth
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else if (start) begin
            tail <= tail + 1'b1;
        end
    end

    assign wr_en  = start;
    assign wr_ptr = tail;

    // result landing in the dispatch cycle, catch it here
    assign src1_bypass = tag_hit(wakeup, dispatch.src1_tag);
    assign src2_bypass = tag_hit(wakeup, dispatch.src2_tag);

    always_comb begin
        wr_entry.inst_num   = dispatch.inst_num;
        wr_entry.pc         = dispatch.pc;
        wr_entry.rd         = dispatch.rd;
        wr_entry.alu_op     = dispatch.alu_op;
        wr_entry.src1_sel   = dispatch.src1_sel;
        wr_entry.src2_sel   = dispatch.src2_sel;
        wr_entry.imm        = dispatch.imm;
        wr_entry.src1_tag   = dispatch.src1_tag;
        wr_entry.src2_tag   = dispatch.src2_tag;
        wr_entry.src1_ready = dispatch.src1_ready | src1_bypass;
        wr_entry.src2_ready = dispatch.src2_ready | src2_bypass;
    end

endmodule

`default_nettype wire

/* rs_alu_chk.sv */
`default_nettype none

module rs_alu_chk import rs_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      flush,
    input logic      wr_en,
    input rs_ptr_t   tail,
    input rs_issue_t issue
);

    // a flushed edge registers an idle packet
    a_idle_after_flush: assert property (@(posedge clk) flush |=> !issue.valid)
        else $error("issue.valid high on the cycle after a flush");

    // an entry leaves once, so back-to-back issues carry different sequence numbers
    a_no_repeat: assert property (@(posedge clk) disable iff (rst)
        (issue.valid && $past(issue.valid)) |-> (issue.inst_num != $past(issue.inst_num)))
        else $error("same instruction issued on two consecutive cycles");

    // every write takes the tail slot and moves the tail on by one
    a_write_moves_tail: assert property (@(posedge clk) disable iff (flush)
        wr_en |=> (tail == rs_ptr_t'($past(tail) + 1'b1)))
        else $error("tail did not advance after a write");

endmodule

bind rs_alu_top rs_alu_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .flush (flush),
    .wr_en (wr_en),
    .tail  (tail),
    .issue (issue)
);

`default_nettype wire

/* rs_alu_top.sv */
`default_nettype none

module rs_alu_top import rs_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         exception_sig,
    input  logic         mret_sig,
    input  logic         start,
    input  rs_dispatch_t dispatch,
    input  wakeup_t      wakeup [rs_num_buses],   // alu, mul, div, load
    output rs_issue_t    issue
);

    logic                flush;
    logic                wr_en;
    rs_ptr_t             wr_ptr;
    rs_entry_t           wr_entry;
    rs_ptr_t             tail;
    rs_ptr_t             head;
    rs_entry_t           entries [rs_depth];
    logic [rs_depth-1:0] ready_vec;
    logic                issue_en;
    rs_ptr_t             issue_ptr;

    // trap and return both squash everything in flight
    assign flush = rst | exception_sig | mret_sig;

    rs_alloc u_alloc (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .start    (start),
        .dispatch (dispatch),
        .wakeup   (wakeup),
        .wr_en    (wr_en),
        .wr_ptr   (wr_ptr),
        .wr_entry (wr_entry),
        .tail     (tail)
    );

    rs_entry_array u_array (
        .clk       (clk),
        .flush     (flush),
        .wr_en     (wr_en),
        .wr_ptr    (wr_ptr),
        .wr_entry  (wr_entry),
        .wakeup    (wakeup),
        .tail      (tail),
        .issue_en  (issue_en),
        .issue_ptr (issue_ptr),
        .entries   (entries),
        .ready_vec (ready_vec),
        .head      (head)
    );

    rs_issue_select u_select (
        .clk       (clk),
        .flush     (flush),
        .head      (head),
        .ready_vec (ready_vec),
        .entries   (entries),
        .issue_en  (issue_en),
        .issue_ptr (issue_ptr),
        .issue     (issue)
    );

endmodule

`default_nettype wire

/* rs_entry_array.sv */
`default_nettype none

module rs_entry_array import rs_pkg::*; (
    input  logic                clk,
    input  logic                flush,
    input  logic                wr_en,
    input  rs_ptr_t             wr_ptr,
    input  rs_entry_t           wr_entry,
    input  wakeup_t             wakeup [rs_num_buses],
    input  rs_ptr_t             tail,
    input  logic                issue_en,
    input  rs_ptr_t             issue_ptr,
    output rs_entry_t           entries [rs_depth],
    output logic [rs_depth-1:0] ready_vec,
    output rs_ptr_t             head
);

    logic [rs_depth-1:0] live;   // written and not yet issued

    // live bits, set on write and cleared on issue
    always_ff @(posedge clk) begin
        if (flush) begin
            live <= '0;
        end else begin
            if (wr_en) begin
                live[wr_ptr] <= 1'b1;
            end
            if (issue_en) begin
                live[issue_ptr] <= 1'b0;
            end
        end
    end

    // head skips over entries that already left
    always_ff @(posedge clk) begin
        if (flush) begin
            head <= '0;
        end else if (!live[head] && (head != tail)) begin
            head <= head + 1'b1;
        end
    end

    for (genvar g = 0; g < rs_depth; g++) begin : g_entry
        logic hit1;
        logic hit2;

        assign hit1 = tag_hit(wakeup, entries[g].src1_tag);
        assign hit2 = tag_hit(wakeup, entries[g].src2_tag);

        always_ff @(posedge clk) begin
            if (wr_en && (wr_ptr == rs_ptr_t'(g))) begin
                entries[g] <= wr_entry;   // bypass already folded in by alloc
            end else begin
                if (hit1) begin
                    entries[g].src1_ready <= 1'b1;
                end
                if (hit2) begin
                    entries[g].src2_ready <= 1'b1;
                end
            end
        end

        // stale ready bits in dead slots are masked by live
        assign ready_vec[g] = live[g] & entries[g].src1_ready & entries[g].src2_ready;
    end

endmodule

`default_nettype wire

/* rs_issue_select.sv */
`default_nettype none

module rs_issue_select import rs_pkg::*; (
    input  logic                clk,
    input  logic                flush,
    input  rs_ptr_t             head,
    input  logic [rs_depth-1:0] ready_vec,
    input  rs_entry_t           entries [rs_depth],
    output logic                issue_en,
    output rs_ptr_t             issue_ptr,
    output rs_issue_t           issue
);

    logic [2*rs_depth-1:0]  rotated;
    logic [rs_window-1:0]   window;
    logic [rs_win_bits-1:0] offset;
    rs_entry_t              sel;
    rs_issue_t              pkt;

    // bit 0 of the window is the head entry, age grows upward
    assign rotated = {ready_vec, ready_vec} >> head;
    assign window  = rotated[rs_window-1:0];

    // lowest set bit is the oldest ready entry
    always_comb begin
        offset = '0;
        for (int i = rs_window - 1; i >= 0; i--) begin
            if (window[i]) begin
                offset = i[rs_win_bits-1:0];
            end
        end
    end

    assign issue_en  = |window;
    assign issue_ptr = head + rs_ptr_t'(offset);   // wraps mod depth
    assign sel       = entries[issue_ptr];

    always_comb begin
        pkt = '0;
        if (issue_en) begin
            pkt.valid    = 1'b1;
            pkt.inst_num = sel.inst_num;
            pkt.pc       = sel.pc;
            pkt.rd       = sel.rd;
            pkt.alu_op   = sel.alu_op;
            pkt.src1_sel = sel.src1_sel;
            pkt.src2_sel = sel.src2_sel;
            pkt.imm      = sel.imm;
            pkt.src1_tag = sel.src1_tag;
            pkt.src2_tag = sel.src2_tag;
        end
    end

    // idle cycles register an all-zero packet
    always_ff @(posedge clk) begin
        if (flush) begin
            issue <= '0;
        end else begin
            issue <= pkt;
        end
    end

endmodule

`default_nettype wire

/* rs_pkg.sv */
`default_nettype none

package rs_pkg;

    localparam int rs_depth     = 64;
    localparam int rs_window    = 32;   // issue search span starting at head
    localparam int rs_win_bits  = $clog2(rs_window);
    localparam int rs_num_buses = 4;    // alu, mul, div, load

    typedef logic [$clog2(rs_depth)-1:0] rs_ptr_t;
    typedef logic [7:0]  phys_tag_t;
    typedef logic [31:0] inst_num_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  alu_op_t;

    // instruction as presented by rename/dispatch
    typedef struct packed {
        inst_num_t inst_num;
        word_t     pc;
        phys_tag_t rd;
        alu_op_t   alu_op;
        logic      src1_sel;
        logic      src2_sel;
        word_t     imm;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        logic      src1_ready;
        logic      src2_ready;
    } rs_dispatch_t;

    // one result broadcast
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } wakeup_t;

    // stored entry, ready bits follow wakeups
    typedef struct packed {
        inst_num_t inst_num;
        word_t     pc;
        phys_tag_t rd;
        alu_op_t   alu_op;
        logic      src1_sel;
        logic      src2_sel;
        word_t     imm;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        logic      src1_ready;
        logic      src2_ready;
    } rs_entry_t;

    typedef struct packed {
        logic      valid;
        inst_num_t inst_num;
        word_t     pc;
        phys_tag_t rd;
        alu_op_t   alu_op;
        logic      src1_sel;
        logic      src2_sel;
        word_t     imm;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
    } rs_issue_t;

    // any valid broadcast carrying this tag
    function automatic logic tag_hit(input wakeup_t wk [rs_num_buses], input phys_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < rs_num_buses; b++) begin
            hit = hit | (wk[b].valid && (wk[b].tag == tag));
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

/* tb_rs_alu.sv */
`default_nettype none

module tb_rs_alu import rs_pkg::*; ();

    localparam int clk_period = 40;
    localparam int n_reset    = 4;

    // one table row is one clock cycle of stimulus
    typedef struct packed {
        logic                         start;
        rs_dispatch_t                 disp;
        logic [rs_num_buses-1:0]      wk_valid;
        phys_tag_t [rs_num_buses-1:0] wk_tag;
        logic [1:0]                   fl;       // 1 exception, 2 mret
    } stim_row_t;

    logic         clk;
    logic         rst;
    logic         exception_sig;
    logic         mret_sig;
    logic         start;
    rs_dispatch_t dispatch;
    wakeup_t      wakeup [rs_num_buses];
    rs_issue_t    issue;

    stim_row_t    rows [$];
    rs_issue_t    exp_q [$];   // expected issue order
    int           n_rows = 0;
    int           seq    = 0;
    int           errors = 0;
    int           checks = 0;
    int           issued = 0;
    integer       seed   = 32'hb4fe_ea12;

    logic         m_live [rs_depth];
    rs_dispatch_t m_ent  [rs_depth];
    int           m_head;
    int           m_tail;

    rs_alu_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .exception_sig (exception_sig),
        .mret_sig      (mret_sig),
        .start         (start),
        .dispatch      (dispatch),
        .wakeup        (wakeup),
        .issue         (issue)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic add_row(input logic st, input phys_tag_t t1, input logic r1,
                           input phys_tag_t t2, input logic r2, input int wbus,
                           input phys_tag_t wtag, input logic wvalid, input logic [1:0] fl);
        stim_row_t r;
        r = '0;
        r.start = st;
        if (st) begin
            r.disp.inst_num   = 32'h0000_1000 + seq;
            r.disp.pc         = $random(seed);
            r.disp.imm        = $random(seed);
            r.disp.rd         = phys_tag_t'(seq);
            r.disp.alu_op     = alu_op_t'(seq);
            r.disp.src1_sel   = seq[0];
            r.disp.src2_sel   = seq[1];
            r.disp.src1_tag   = t1;
            r.disp.src2_tag   = t2;
            r.disp.src1_ready = r1;
            r.disp.src2_ready = r2;
            seq++;
        end
        if (wbus >= 0) begin
            r.wk_valid[wbus] = wvalid;
            r.wk_tag[wbus]   = wtag;
        end
        r.fl = fl;
        rows.push_back(r);
    endtask

    task automatic add_ready(input int n);
        repeat (n) begin
            add_row(1'b1, phys_tag_t'(seq), 1'b1, phys_tag_t'(seq + 1), 1'b1,
                    -1, '0, 1'b0, 2'd0);
        end
    endtask

    task automatic add_idle(input int n);
        repeat (n) begin
            add_row(1'b0, '0, 1'b0, '0, 1'b0, -1, '0, 1'b0, 2'd0);
        end
    endtask

    task automatic add_wake(input int bus, input phys_tag_t tag, input logic valid);
        add_row(1'b0, '0, 1'b0, '0, 1'b0, bus, tag, valid, 2'd0);
    endtask

    task automatic add_flush(input logic [1:0] kind);
        add_row(1'b0, '0, 1'b0, '0, 1'b0, -1, '0, 1'b0, kind);
    endtask

    task automatic build_table();
        add_ready(6);
        add_idle(3);
        // waiting entries get overtaken by younger ready ones
        add_row(1'b1, 8'ha1, 1'b0, 8'h05, 1'b1, -1, '0, 1'b0, 2'd0);
        add_ready(3);
        add_row(1'b1, 8'ha2, 1'b0, 8'ha3, 1'b0, -1, '0, 1'b0, 2'd0);
        add_ready(2);
        add_idle(2);
        add_wake(1, 8'ha1, 1'b0);   // valid low, must not wake
        add_ready(1);               // goes ahead of the waiting entry only if nothing woke
        add_idle(2);
        add_wake(2, 8'ha1, 1'b1);
        add_idle(2);
        add_wake(0, 8'ha2, 1'b1);
        add_idle(2);
        add_wake(3, 8'ha3, 1'b1);
        add_idle(3);
        // result lands in the dispatch cycle
        add_row(1'b1, 8'ha4, 1'b0, 8'h07, 1'b1, 3, 8'ha4, 1'b1, 2'd0);
        add_row(1'b1, 8'h09, 1'b1, 8'ha5, 1'b0, 1, 8'ha5, 1'b1, 2'd0);
        add_idle(3);
        repeat (3) begin
            add_row(1'b1, 8'ha6, 1'b0, 8'h0b, 1'b1, -1, '0, 1'b0, 2'd0);
        end
        add_idle(1);
        add_flush(2'd1);
        add_wake(0, 8'ha6, 1'b1);
        add_ready(2);
        add_idle(2);
        repeat (2) begin
            add_row(1'b1, 8'h0c, 1'b1, 8'ha7, 1'b0, -1, '0, 1'b0, 2'd0);
        end
        add_flush(2'd2);
        add_wake(2, 8'ha7, 1'b1);
        add_ready(2);
        add_idle(3);
        // blocked head, the two youngest fall outside the window
        add_flush(2'd2);
        add_row(1'b1, 8'ha8, 1'b0, 8'h0d, 1'b1, -1, '0, 1'b0, 2'd0);
        add_ready(33);
        add_idle(4);
        add_wake(1, 8'ha8, 1'b1);
        add_idle(6);
    endtask

    function automatic logic bus_hit(input stim_row_t r, input phys_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < rs_num_buses; b++) begin
            if (r.wk_valid[b] && (r.wk_tag[b] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic model_clear();
        for (int i = 0; i < rs_depth; i++) begin
            m_live[i] = 1'b0;
            m_ent[i]  = '0;
        end
        m_head = 0;
        m_tail = 0;
    endtask

    // what the station does at the coming edge
    task automatic model_step(input stim_row_t r);
        int        pick;
        int        idx;
        rs_issue_t pkt;
        if (r.fl != 2'd0) begin
            model_clear();
            return;
        end
        pick = -1;
        for (int k = 0; k < rs_window; k++) begin
            idx = (m_head + k) % rs_depth;
            if (pick < 0 && m_live[idx] && m_ent[idx].src1_ready && m_ent[idx].src2_ready) begin
                pick = idx;
            end
        end
        if (pick >= 0) begin
            pkt          = '0;
            pkt.valid    = 1'b1;
            pkt.inst_num = m_ent[pick].inst_num;
            pkt.pc       = m_ent[pick].pc;
            pkt.rd       = m_ent[pick].rd;
            pkt.alu_op   = m_ent[pick].alu_op;
            pkt.src1_sel = m_ent[pick].src1_sel;
            pkt.src2_sel = m_ent[pick].src2_sel;
            pkt.imm      = m_ent[pick].imm;
            pkt.src1_tag = m_ent[pick].src1_tag;
            pkt.src2_tag = m_ent[pick].src2_tag;
            exp_q.push_back(pkt);
        end
        if (!m_live[m_head] && (m_head != m_tail)) begin
            m_head = (m_head + 1) % rs_depth;
        end
        for (int i = 0; i < rs_depth; i++) begin
            if (bus_hit(r, m_ent[i].src1_tag)) begin
                m_ent[i].src1_ready = 1'b1;
            end
            if (bus_hit(r, m_ent[i].src2_tag)) begin
                m_ent[i].src2_ready = 1'b1;
            end
        end
        if (r.start) begin
            m_ent[m_tail]            = r.disp;
            m_ent[m_tail].src1_ready = r.disp.src1_ready | bus_hit(r, r.disp.src1_tag);
            m_ent[m_tail].src2_ready = r.disp.src2_ready | bus_hit(r, r.disp.src2_tag);
            m_live[m_tail]           = 1'b1;
            m_tail                   = (m_tail + 1) % rs_depth;
        end
        if (pick >= 0) begin
            m_live[pick] = 1'b0;
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_issue();
        rs_issue_t e;
        if (issue.valid === 1'b0) begin
            return;
        end
        issued++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("instruction %h issued although no instruction was ready", issue.inst_num);
            return;
        end
        e = exp_q.pop_front();
        check_val("issue.valid", issue.valid, 1'b1);
        check_val("issue.inst_num", issue.inst_num, e.inst_num);
        check_val("issue.pc", issue.pc, e.pc);
        check_val("issue.rd", issue.rd, e.rd);
        check_val("issue.alu_op", issue.alu_op, e.alu_op);
        check_val("issue.src1_sel", issue.src1_sel, e.src1_sel);
        check_val("issue.src2_sel", issue.src2_sel, e.src2_sel);
        check_val("issue.imm", issue.imm, e.imm);
        check_val("issue.src1_tag", issue.src1_tag, e.src1_tag);
        check_val("issue.src2_tag", issue.src2_tag, e.src2_tag);
    endtask

    task automatic apply_row(input stim_row_t r);
        start         = r.start;
        dispatch      = r.disp;
        exception_sig = (r.fl == 2'd1);
        mret_sig      = (r.fl == 2'd2);
        for (int b = 0; b < rs_num_buses; b++) begin
            wakeup[b].valid = r.wk_valid[b];
            wakeup[b].tag   = r.wk_tag[b];
        end
    endtask

    // drive at the falling edge, look at the packet one falling edge later
    task automatic step_cycle(input stim_row_t r);
        apply_row(r);
        model_step(r);
        @(negedge clk);
        check_issue();
    endtask

    initial begin
        stim_row_t idle_row;
        idle_row      = '0;
        rst           = 1'b1;
        exception_sig = 1'b0;
        mret_sig      = 1'b0;
        start         = 1'b0;
        dispatch      = '0;
        for (int b = 0; b < rs_num_buses; b++) begin
            wakeup[b] = '0;
        end
        build_table();
        n_rows = rows.size();
        model_clear();
        repeat (n_reset) @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            step_cycle(rows[i]);
        end
        while (exp_q.size() != 0) begin
            step_cycle(idle_row);
        end
        $display("checks %0d, issued %0d, errors %0d", checks, issued, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (n_rows > 0);
        #((n_rows + 200) * clk_period);
        $display("timeout: %0d expected issues still pending", exp_q.size());
        $display("checks %0d, issued %0d, errors %0d", checks, issued, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
